// File: hdl/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

	// cache geometry
	localparam int WAYS       = 4;
	localparam int LINE_BEATS = 8;
	localparam int SETS       = 32;
	localparam int SET_BITS   = $clog2(SETS);
	localparam int BEAT_BITS  = $clog2(LINE_BEATS);

	typedef logic [29:0] cpu_addr_t; // word address
	typedef logic [31:0] cpu_data_t;
	typedef logic [3:0]  cpu_be_t;
	typedef logic [63:0] ddr_data_t;
	typedef logic [7:0]  ddr_be_t;
	typedef logic [3:0]  burst_t;
	typedef logic [1:0]  way_t;
	typedef logic [16:0] vga_addr_t; // byte address

	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t din;
		cpu_be_t   be;
		burst_t    burstcnt;
		logic      rd;
		logic      we;
	} cpu_req_s;

	typedef struct packed {
		logic ram;
		logic rom;
		logic vga;
		logic behind; // above installed RAM
	} region_s;

	typedef struct packed {
		logic      from_vga;
		way_t      way;
		cpu_data_t word;
	} read_ret_s;

	typedef enum logic [2:0] {
		INIT,
		IDLE,
		LOOKUP,
		FILL,
		TAG_WRITE,
		WRITE_THROUGH,
		VGA_READ,
		VGA_WRITE
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/cpu_region_decode.sv
`default_nettype none

module cpu_region_decode #(
	parameter int ADDR_BITS = 24
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic [2:0]             vga_mode,
	input  l2_cache_pkg::cpu_req_s req,
	output l2_cache_pkg::region_s  region
);

	logic [1:0] vga_mask;
	logic [1:0] vga_cmp;

	// window select within 0xA0000-0xBFFFF
	always_ff @(posedge CLK) begin
		case (vga_mode)
			3'b100: begin // 128K
				vga_mask <= 2'b00;
				vga_cmp  <= 2'b00;
			end
			3'b101: begin // lower 64K
				vga_mask <= 2'b10;
				vga_cmp  <= 2'b00;
			end
			3'b110: begin // 3rd 32K
				vga_mask <= 2'b11;
				vga_cmp  <= 2'b10;
			end
			3'b111: begin // top 32K
				vga_mask <= 2'b11;
				vga_cmp  <= 2'b11;
			end
			default: begin // no window
				vga_mask <= 2'b00;
				vga_cmp  <= 2'b11;
			end
		endcase
		if (!rst_n) begin
			vga_mask <= 2'b00;
			vga_cmp  <= 2'b11;
		end
	end

	always_comb begin
		region.ram    = req.addr[29:ADDR_BITS+2] == '0;
		region.behind = !region.ram;
		region.rom    = region.ram && (req.addr[ADDR_BITS+1:16] == 'h3); // 0xC0000-0xFFFFF
		region.vga    = region.ram && (req.addr[ADDR_BITS+1:15] == 'h5)
			&& ((req.addr[14:13] & vga_mask) == vga_cmp);
	end

endmodule

`default_nettype wire

// File: hdl/cache_way_store.sv
`default_nettype none

module cache_way_store #(
	parameter int ADDR_BITS = 24
) (
	input  logic                                   CLK,
	input  logic                                   rst_n,
	input  logic [l2_cache_pkg::SET_BITS-1:0]      index,
	input  logic [ADDR_BITS-l2_cache_pkg::SET_BITS-l2_cache_pkg::BEAT_BITS:0] tag,
	input  l2_cache_pkg::way_t                     fill_way,
	input  logic                                   fill_we,
	input  logic [l2_cache_pkg::BEAT_BITS-1:0]     beat,
	input  l2_cache_pkg::ddr_data_t                fill_data,
	input  l2_cache_pkg::ddr_data_t                wr_data,
	input  l2_cache_pkg::ddr_be_t                  wr_be,
	input  logic                                   wr_hit_we,
	input  logic                                   tag_we,
	input  logic                                   clear_we,
	input  logic                                   touch,
	output logic                                   hit,
	output l2_cache_pkg::way_t                     hit_way,
	output l2_cache_pkg::way_t                     victim,
	output l2_cache_pkg::cpu_data_t                rd_word,
	input  logic                                   rd_half
);

	localparam int WAYS = l2_cache_pkg::WAYS;
	localparam int SETS = l2_cache_pkg::SETS;
	localparam int LINE_BITS = l2_cache_pkg::SET_BITS + l2_cache_pkg::BEAT_BITS;
	localparam int TAG_BITS = ADDR_BITS + 1 - LINE_BITS;

	logic [TAG_BITS-1:0]     tag_mem  [WAYS][SETS];
	logic [WAYS-1:0]         valid    [SETS];
	l2_cache_pkg::way_t      age      [SETS][WAYS]; // 0 = most recent
	l2_cache_pkg::ddr_data_t data_mem [WAYS][SETS * l2_cache_pkg::LINE_BEATS];
	logic [LINE_BITS-1:0]    line_addr;
	l2_cache_pkg::ddr_data_t rd_beat;

	assign line_addr = {index, beat};

	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		victim  = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid[index][w] && tag_mem[w][index] == tag) begin
				hit     = 1'b1;
				hit_way = l2_cache_pkg::way_t'(w);
			end
			if (age[index][w] == l2_cache_pkg::way_t'(WAYS - 1))
				victim = l2_cache_pkg::way_t'(w);
		end
	end

	assign rd_beat = data_mem[hit_way][line_addr];
	assign rd_word = rd_half ? rd_beat[63:32] : rd_beat[31:0];

	always_ff @(posedge CLK) begin
		if (fill_we)
			data_mem[fill_way][line_addr] <= fill_data;
		else if (wr_hit_we && hit) begin
			for (int b = 0; b < 8; b++)
				if (wr_be[b])
					data_mem[hit_way][line_addr][8*b +: 8] <= wr_data[8*b +: 8];
		end
		if (tag_we)
			tag_mem[fill_way][index] <= tag;
	end

	always_ff @(posedge CLK) begin
		if (clear_we) begin
			valid[index] <= '0;
			for (int w = 0; w < WAYS; w++)
				age[index][w] <= l2_cache_pkg::way_t'(w);
		end else begin
			if (tag_we)
				valid[index][fill_way] <= 1'b1;
			if (touch) begin
				for (int w = 0; w < WAYS; w++) begin
					if (l2_cache_pkg::way_t'(w) == hit_way)
						age[index][w] <= '0;
					else if (age[index][w] < age[index][hit_way])
						age[index][w] <= age[index][w] + 1'b1; // younger ones age by one
				end
			end
		end
		if (!rst_n)
			for (int s = 0; s < SETS; s++)
				valid[s] <= '0;
	end

endmodule

`default_nettype wire

// File: hdl/l2_cache_ctrl.sv
`default_nettype none

module l2_cache_ctrl #(
	parameter int ADDR_BITS = 24
) (
	input  logic                               CLK,
	input  logic                               rst_n,
	input  l2_cache_pkg::cpu_req_s             req,
	input  l2_cache_pkg::region_s              region,
	output logic                               cpu_busy,
	output logic [ADDR_BITS:0]                 ddr_addr,
	output l2_cache_pkg::ddr_data_t            ddr_din,
	output l2_cache_pkg::ddr_be_t              ddr_be,
	output logic [7:0]                         ddr_burstcnt,
	output logic                               ddr_rd,
	output logic                               ddr_we,
	input  logic                               ddr_dout_ready,
	input  logic                               ddr_busy,
	output logic [l2_cache_pkg::SET_BITS-1:0]  index,
	output logic [ADDR_BITS-l2_cache_pkg::SET_BITS-l2_cache_pkg::BEAT_BITS:0] tag,
	output l2_cache_pkg::way_t                 fill_way,
	output logic                               fill_we,
	output logic [l2_cache_pkg::BEAT_BITS-1:0] beat,
	output logic                               wr_hit_we,
	output logic                               tag_we,
	output logic                               clear_we,
	output logic                               touch,
	output logic                               rd_half,
	input  logic                               hit,
	input  l2_cache_pkg::way_t                 hit_way,
	input  l2_cache_pkg::way_t                 victim,
	output logic                               vga_start,
	output l2_cache_pkg::cpu_req_s             vga_req,
	input  logic                               vga_done,
	input  l2_cache_pkg::cpu_data_t            vga_word,
	output logic                               ret_valid,
	output l2_cache_pkg::read_ret_s            ret
);

	localparam int SB = l2_cache_pkg::SET_BITS;
	localparam int BB = l2_cache_pkg::BEAT_BITS;

	l2_cache_pkg::ctrl_state_e state;
	l2_cache_pkg::cpu_req_s    req_q;
	l2_cache_pkg::region_s     region_q;
	l2_cache_pkg::cpu_addr_t   cur_addr; // steps per burst beat
	l2_cache_pkg::burst_t      left;
	l2_cache_pkg::way_t        victim_q;
	logic [SB-1:0]             init_cnt;
	logic [BB-1:0]             fill_cnt;

	assign cpu_busy = (state == l2_cache_pkg::IDLE) ? ddr_busy : 1'b1;
	assign vga_req  = req_q;

	assign index   = (state == l2_cache_pkg::INIT) ? init_cnt : cur_addr[SB+BB:BB+1];
	assign tag     = cur_addr[ADDR_BITS+1:SB+BB+1];
	assign beat    = (state == l2_cache_pkg::FILL) ? fill_cnt : cur_addr[BB:1];
	assign rd_half = cur_addr[0];

	assign clear_we  = state == l2_cache_pkg::INIT;
	assign fill_we   = state == l2_cache_pkg::FILL && ddr_dout_ready;
	assign tag_we    = state == l2_cache_pkg::TAG_WRITE;
	assign wr_hit_we = state == l2_cache_pkg::WRITE_THROUGH && hit && !ddr_busy;
	assign touch     = state == l2_cache_pkg::LOOKUP && hit && !region_q.behind;
	assign fill_way  = ret.way;

	assign ret_valid = (state == l2_cache_pkg::LOOKUP && (hit || region_q.behind))
		|| (state == l2_cache_pkg::VGA_READ && vga_done);

	always_comb begin
		ret.from_vga = region_q.behind || state == l2_cache_pkg::VGA_READ;
		ret.way      = (state == l2_cache_pkg::LOOKUP) ? hit_way : victim_q;
		ret.word     = region_q.behind ? '0 : vga_word; // zero above RAM
	end

	always_ff @(posedge CLK) begin
		vga_start <= 1'b0;
		if (!ddr_busy) begin
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;
		end

		case (state)
			l2_cache_pkg::INIT: begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == SB'(l2_cache_pkg::SETS - 1))
					state <= l2_cache_pkg::IDLE;
			end

			l2_cache_pkg::IDLE: begin
				if (!ddr_busy && (req.rd || req.we)) begin
					req_q        <= req;
					region_q     <= region;
					cur_addr     <= req.addr;
					left         <= req.burstcnt;
					ddr_addr     <= req.addr[ADDR_BITS+1:1];
					ddr_burstcnt <= 8'd1;
					ddr_din      <= {req.din, req.din};
					ddr_be       <= req.addr[0] ? {req.be, 4'h0} : {4'h0, req.be};
					if (req.rd) begin
						if (region.vga) begin
							vga_start <= 1'b1;
							state     <= l2_cache_pkg::VGA_READ;
						end else
							state <= l2_cache_pkg::LOOKUP;
					end else if (region.ram && !region.rom) begin
						if (region.vga) begin
							vga_start <= 1'b1;
							state     <= l2_cache_pkg::VGA_WRITE;
						end else begin
							ddr_we <= 1'b1;
							state  <= l2_cache_pkg::WRITE_THROUGH;
						end
					end
				end
			end

			l2_cache_pkg::LOOKUP: begin
				if (hit || region_q.behind) begin
					if (left > 4'd1) begin
						left     <= left - 1'b1;
						cur_addr <= cur_addr + 1'b1;
					end else
						state <= l2_cache_pkg::IDLE;
				end else begin
					// miss, fetch the whole line into the LRU way
					ddr_rd       <= 1'b1;
					ddr_addr     <= {cur_addr[ADDR_BITS+1:BB+1], {BB{1'b0}}};
					ddr_burstcnt <= 8'(l2_cache_pkg::LINE_BEATS);
					fill_cnt     <= '0;
					victim_q     <= victim;
					state        <= l2_cache_pkg::FILL;
				end
			end

			l2_cache_pkg::FILL: begin
				if (ddr_dout_ready) begin
					fill_cnt <= fill_cnt + 1'b1;
					if (fill_cnt == BB'(l2_cache_pkg::LINE_BEATS - 1))
						state <= l2_cache_pkg::TAG_WRITE;
				end
			end

			l2_cache_pkg::TAG_WRITE:
				state <= l2_cache_pkg::LOOKUP; // re-lookup now hits

			l2_cache_pkg::WRITE_THROUGH:
				if (!ddr_busy)
					state <= l2_cache_pkg::IDLE;

			l2_cache_pkg::VGA_READ: begin
				if (vga_done) begin
					if (left > 4'd1)
						left <= left - 1'b1;
					else
						state <= l2_cache_pkg::IDLE;
				end
			end

			l2_cache_pkg::VGA_WRITE:
				if (vga_done)
					state <= l2_cache_pkg::IDLE;

			default:
				state <= l2_cache_pkg::IDLE;
		endcase

		if (!rst_n) begin
			state     <= l2_cache_pkg::INIT;
			init_cnt  <= '0;
			ddr_rd    <= 1'b0;
			ddr_we    <= 1'b0;
			vga_start <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/vga_byte_bridge.sv
`default_nettype none

module vga_byte_bridge (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    start,
	input  l2_cache_pkg::cpu_req_s  req,
	output logic                    done,
	output l2_cache_pkg::cpu_data_t word,
	output l2_cache_pkg::vga_addr_t vga_addr,
	output logic [7:0]              vga_dout,
	input  logic [7:0]              vga_din,
	output logic                    vga_rd,
	output logic                    vga_we
);

	typedef enum logic [2:0] {
		B_IDLE,
		B_WRITE,
		B_RD_ISSUE,
		B_RD_WAIT,
		B_RD_TAKE
	} bridge_state_e;

	bridge_state_e           state;
	l2_cache_pkg::cpu_data_t sh;    // write bytes out low first, read bytes in high
	l2_cache_pkg::cpu_be_t   be_sh;
	l2_cache_pkg::burst_t    left;
	logic [14:0]             wa;
	logic [1:0]              ba;
	logic [1:0]              lead;

	// first enabled byte
	always_comb begin
		casez (req.be)
			4'b???1: lead = 2'd0;
			4'b??10: lead = 2'd1;
			4'b?100: lead = 2'd2;
			default: lead = 2'd3;
		endcase
	end

	assign vga_addr = {wa, ba};
	assign vga_dout = sh[7:0];
	assign vga_we   = state == B_WRITE && be_sh[0];
	assign vga_rd   = state == B_RD_ISSUE;
	assign word     = sh;

	always_ff @(posedge CLK) begin
		done <= 1'b0;
		case (state)
			B_IDLE: begin
				if (start) begin
					wa   <= req.addr[14:0];
					left <= req.burstcnt;
					if (req.we) begin
						sh    <= req.din >> {lead, 3'b000};
						be_sh <= req.be >> lead;
						ba    <= lead;
						state <= B_WRITE;
					end else begin
						ba    <= 2'd0;
						state <= B_RD_ISSUE;
					end
				end
			end

			B_WRITE: begin
				sh    <= sh >> 8;
				be_sh <= be_sh >> 1;
				ba    <= ba + 1'b1;
				if (be_sh[3:1] == 3'b000) begin // last enabled byte
					done  <= 1'b1;
					state <= B_IDLE;
				end
			end

			B_RD_ISSUE:
				state <= B_RD_WAIT;

			B_RD_WAIT:
				state <= B_RD_TAKE; // data lands two cycles after the strobe

			B_RD_TAKE: begin
				sh    <= {vga_din, sh[31:8]};
				ba    <= ba + 1'b1;
				state <= B_RD_ISSUE;
				if (ba == 2'd3) begin
					done <= 1'b1;
					if (left > 4'd1) begin
						left <= left - 1'b1;
						wa   <= wa + 1'b1;
					end else
						state <= B_IDLE;
				end
			end

			default:
				state <= B_IDLE;
		endcase

		if (!rst_n) begin
			state <= B_IDLE;
			done  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cpu_read_return.sv
`default_nettype none

module cpu_read_return (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    ret_valid,
	input  l2_cache_pkg::read_ret_s ret,
	input  l2_cache_pkg::cpu_data_t cache_word,
	output l2_cache_pkg::cpu_data_t cpu_dout,
	output logic                    cpu_dout_ready
);

	always_ff @(posedge CLK) begin
		cpu_dout_ready <= ret_valid;
		if (ret_valid)
			cpu_dout <= ret.from_vga ? ret.word : cache_word; // word is zero above RAM
		if (!rst_n)
			cpu_dout_ready <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/l2_cache_top.sv
`default_nettype none

module l2_cache_top #(
	parameter int ADDR_BITS = 24
) (
	input  logic                    CLK,
	input  logic                    rst_n,

	input  l2_cache_pkg::cpu_addr_t CPU_ADDR,
	input  l2_cache_pkg::cpu_data_t CPU_DIN,
	input  l2_cache_pkg::cpu_be_t   CPU_BE,
	input  l2_cache_pkg::burst_t    CPU_BURSTCNT,
	input  logic                    CPU_RD,
	input  logic                    CPU_WE,
	output l2_cache_pkg::cpu_data_t CPU_DOUT,
	output logic                    CPU_DOUT_READY,
	output logic                    CPU_BUSY,

	output logic [ADDR_BITS:0]      DDRAM_ADDR,
	output l2_cache_pkg::ddr_data_t DDRAM_DIN,
	output l2_cache_pkg::ddr_be_t   DDRAM_BE,
	output logic [7:0]              DDRAM_BURSTCNT,
	output logic                    DDRAM_RD,
	output logic                    DDRAM_WE,
	input  l2_cache_pkg::ddr_data_t DDRAM_DOUT,
	input  logic                    DDRAM_DOUT_READY,
	input  logic                    DDRAM_BUSY,

	output l2_cache_pkg::vga_addr_t VGA_ADDR,
	output logic [7:0]              VGA_DOUT,
	output logic                    VGA_RD,
	output logic                    VGA_WE,
	input  logic [7:0]              VGA_DIN,
	input  logic [2:0]              VGA_MODE
);

	localparam int TAG_BITS = ADDR_BITS + 1 - l2_cache_pkg::SET_BITS - l2_cache_pkg::BEAT_BITS;

	wire l2_cache_pkg::cpu_req_s req = {CPU_ADDR, CPU_DIN, CPU_BE, CPU_BURSTCNT, CPU_RD, CPU_WE};

	l2_cache_pkg::region_s                region;
	logic [l2_cache_pkg::SET_BITS-1:0]    index;
	logic [TAG_BITS-1:0]                  tag;
	l2_cache_pkg::way_t                   fill_way;
	logic                                 fill_we;
	logic [l2_cache_pkg::BEAT_BITS-1:0]   beat;
	logic                                 wr_hit_we;
	logic                                 tag_we;
	logic                                 clear_we;
	logic                                 touch;
	logic                                 rd_half;
	logic                                 hit;
	l2_cache_pkg::way_t                   hit_way;
	l2_cache_pkg::way_t                   victim;
	l2_cache_pkg::cpu_data_t              cache_word;
	logic                                 vga_start;
	l2_cache_pkg::cpu_req_s               vga_req;
	logic                                 vga_done;
	l2_cache_pkg::cpu_data_t              vga_word;
	logic                                 ret_valid;
	l2_cache_pkg::read_ret_s              ret;

	cpu_region_decode #(.ADDR_BITS(ADDR_BITS)) cpu_region_decode_i (
		.CLK(CLK), .rst_n(rst_n), .vga_mode(VGA_MODE), .req(req), .region(region)
	);

	cache_way_store #(.ADDR_BITS(ADDR_BITS)) cache_way_store_i (
		.CLK(CLK), .rst_n(rst_n), .index(index), .tag(tag),
		.fill_way(fill_way), .fill_we(fill_we), .beat(beat), .fill_data(DDRAM_DOUT),
		.wr_data(DDRAM_DIN), .wr_be(DDRAM_BE), .wr_hit_we(wr_hit_we),
		.tag_we(tag_we), .clear_we(clear_we), .touch(touch),
		.hit(hit), .hit_way(hit_way), .victim(victim), .rd_word(cache_word), .rd_half(rd_half)
	);

	l2_cache_ctrl #(.ADDR_BITS(ADDR_BITS)) l2_cache_ctrl_i (
		.CLK(CLK), .rst_n(rst_n), .req(req), .region(region), .cpu_busy(CPU_BUSY),
		.ddr_addr(DDRAM_ADDR), .ddr_din(DDRAM_DIN), .ddr_be(DDRAM_BE),
		.ddr_burstcnt(DDRAM_BURSTCNT), .ddr_rd(DDRAM_RD), .ddr_we(DDRAM_WE),
		.ddr_dout_ready(DDRAM_DOUT_READY), .ddr_busy(DDRAM_BUSY),
		.index(index), .tag(tag), .fill_way(fill_way), .fill_we(fill_we), .beat(beat),
		.wr_hit_we(wr_hit_we), .tag_we(tag_we), .clear_we(clear_we), .touch(touch),
		.rd_half(rd_half), .hit(hit), .hit_way(hit_way), .victim(victim),
		.vga_start(vga_start), .vga_req(vga_req), .vga_done(vga_done), .vga_word(vga_word),
		.ret_valid(ret_valid), .ret(ret)
	);

	vga_byte_bridge vga_byte_bridge_i (
		.CLK(CLK), .rst_n(rst_n), .start(vga_start), .req(vga_req), .done(vga_done),
		.word(vga_word), .vga_addr(VGA_ADDR), .vga_dout(VGA_DOUT), .vga_din(VGA_DIN),
		.vga_rd(VGA_RD), .vga_we(VGA_WE)
	);

	cpu_read_return cpu_read_return_i (
		.CLK(CLK), .rst_n(rst_n), .ret_valid(ret_valid), .ret(ret), .cache_word(cache_word),
		.cpu_dout(CPU_DOUT), .cpu_dout_ready(CPU_DOUT_READY)
	);

endmodule

`default_nettype wire

// File: sim/mem_models.sv
`default_nettype none

module ddr_model #(
	parameter int ADDR_BITS = 24
) (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic [ADDR_BITS:0]      addr,
	input  l2_cache_pkg::ddr_data_t din,
	input  l2_cache_pkg::ddr_be_t   be,
	input  logic [7:0]              burstcnt,
	input  logic                    rd,
	input  logic                    we,
	output l2_cache_pkg::ddr_data_t dout,
	output logic                    dout_ready,
	output logic                    busy
);
	timeunit 1ns;
	timeprecision 100ps;

	l2_cache_pkg::ddr_data_t mem [1 << 17]; // lowest 1MB only
	logic [16:0] raddr;
	logic [7:0]  left;
	logic [1:0]  gap;
	logic [2:0]  tick;

	initial begin
		left       = '0;
		tick       = '0;
		dout_ready = 1'b0;
		for (int i = 0; i < (1 << 17); i++)
			mem[i] = {17'(i), 15'h1e3c, 17'(i), 15'h06a5};
	end

	assign busy = left != 0 || tick == 3'd5; // periodic back-pressure

	always @(posedge CLK) begin
		dout_ready <= 1'b0;
		tick       <= tick + 1'b1;
		if (!rst_n) begin
			left <= '0;
			tick <= '0;
		end else if (rd && !busy) begin
			raddr <= addr[16:0];
			left  <= burstcnt;
			gap   <= 2'd3; // access latency
		end else if (left != 0) begin
			if (gap != 0)
				gap <= gap - 1'b1;
			else begin
				dout       <= mem[raddr];
				dout_ready <= 1'b1;
				raddr      <= raddr + 1'b1;
				left       <= left - 1'b1;
			end
		end
		if (rst_n && we && !busy)
			for (int b = 0; b < 8; b++)
				if (be[b])
					mem[addr[16:0]][8*b +: 8] <= din[8*b +: 8];
	end

endmodule

module vga_mem_model (
	input  logic                    CLK,
	input  l2_cache_pkg::vga_addr_t addr,
	input  logic [7:0]              wdata,
	input  logic                    rd,
	input  logic                    we,
	output logic [7:0]              rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] mem [1 << 17];
	logic [7:0] rd_q;

	initial begin
		rd_q  = '0;
		rdata = '0;
		for (int i = 0; i < (1 << 17); i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ {i[16], 7'h35};
	end

	always @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
		if (rd)
			rd_q <= mem[addr];
		rdata <= rd_q; // two cycles after the strobe
	end

endmodule

`default_nettype wire

// File: sim/tb_l2_cache.sv
`default_nettype none

module tb_l2_cache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 4000;
	localparam int MEM_SIZE   = 1 << 17;

	logic                    CLK = 1'b0;
	logic                    rst_n;
	l2_cache_pkg::cpu_addr_t CPU_ADDR;
	l2_cache_pkg::cpu_data_t CPU_DIN;
	l2_cache_pkg::cpu_be_t   CPU_BE;
	l2_cache_pkg::burst_t    CPU_BURSTCNT;
	logic                    CPU_RD;
	logic                    CPU_WE;
	l2_cache_pkg::cpu_data_t CPU_DOUT;
	logic                    CPU_DOUT_READY;
	logic                    CPU_BUSY;
	logic [24:0]             DDRAM_ADDR;
	l2_cache_pkg::ddr_data_t DDRAM_DIN;
	l2_cache_pkg::ddr_be_t   DDRAM_BE;
	logic [7:0]              DDRAM_BURSTCNT;
	logic                    DDRAM_RD;
	logic                    DDRAM_WE;
	l2_cache_pkg::ddr_data_t DDRAM_DOUT;
	logic                    DDRAM_DOUT_READY;
	logic                    DDRAM_BUSY;
	l2_cache_pkg::vga_addr_t VGA_ADDR;
	logic [7:0]              VGA_DOUT;
	logic                    VGA_RD;
	logic                    VGA_WE;
	logic [7:0]              VGA_DIN;
	logic [2:0]              VGA_MODE;

	l2_cache_pkg::ddr_data_t ddr_ref [MEM_SIZE]; // expected DDR beats
	logic [7:0]              vga_ref [MEM_SIZE];
	l2_cache_pkg::cpu_data_t exp_q [$];
	logic [1:0]              vga_offs [$];
	int   cyc = 0;
	int   errors = 0;
	int   test_errs = 0;
	int   failed_tests = 0;
	int   acc_cyc = 0;
	int   ready_cyc = 0;
	int   ddr_rd_cnt = 0;
	int   ddr_we_cnt = 0;
	int   vga_we_cnt = 0;
	logic no_ddr_rd = 1'b0;
	logic no_ddr_we = 1'b0;

	always #20 CLK = ~CLK;

	l2_cache_top #(.ADDR_BITS(24)) l2_cache_top_i (.*);

	ddr_model #(.ADDR_BITS(24)) ddr_model_i (
		.CLK(CLK), .rst_n(rst_n), .addr(DDRAM_ADDR), .din(DDRAM_DIN), .be(DDRAM_BE),
		.burstcnt(DDRAM_BURSTCNT), .rd(DDRAM_RD), .we(DDRAM_WE), .dout(DDRAM_DOUT),
		.dout_ready(DDRAM_DOUT_READY), .busy(DDRAM_BUSY)
	);

	vga_mem_model vga_mem_model_i (
		.CLK(CLK), .addr(VGA_ADDR), .wdata(VGA_DOUT), .rd(VGA_RD), .we(VGA_WE), .rdata(VGA_DIN)
	);

	function automatic l2_cache_pkg::ddr_data_t ddr_fill(input logic [16:0] a);
		return {a, 15'h1e3c, a, 15'h06a5};
	endfunction

	function automatic logic [7:0] vga_fill(input logic [16:0] a);
		return a[7:0] ^ a[15:8] ^ {a[16], 7'h35};
	endfunction

	function automatic l2_cache_pkg::cpu_data_t ref_word(input l2_cache_pkg::cpu_addr_t a);
		l2_cache_pkg::ddr_data_t beat;
		beat = ddr_ref[a[17:1]];
		return a[0] ? beat[63:32] : beat[31:0];
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic test_end(input int num, input string name);
		if (errors == test_errs)
			$display("test %0d %s: ok", num, name);
		else begin
			$display("test %0d %s: failed with %0d errors", num, name, errors - test_errs);
			failed_tests++;
		end
		test_errs = errors;
	endtask

	// holds the request until an edge with CPU_BUSY low
	task automatic cpu_request(input l2_cache_pkg::cpu_addr_t a, input l2_cache_pkg::cpu_data_t d,
			input l2_cache_pkg::cpu_be_t be, input l2_cache_pkg::burst_t n,
			input logic rd, input logic we);
		CPU_ADDR     = a;
		CPU_DIN      = d;
		CPU_BE       = be;
		CPU_BURSTCNT = n;
		CPU_RD       = rd;
		CPU_WE       = we;
		@(negedge CLK);
		while (CPU_BUSY)
			@(negedge CLK);
		acc_cyc = cyc;
		@(posedge CLK);
		#2;
		CPU_RD = 1'b0;
		CPU_WE = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge CLK);
		while (CPU_BUSY)
			@(negedge CLK);
		@(posedge CLK);
		#2;
	endtask

	task automatic issue_read(input l2_cache_pkg::cpu_addr_t a, input l2_cache_pkg::burst_t n);
		cpu_request(a, '0, '0, n, 1'b1, 1'b0);
		wait (exp_q.size() == 0);
		@(posedge CLK);
		#2;
	endtask

	task automatic read_ddr(input l2_cache_pkg::cpu_addr_t a, input l2_cache_pkg::burst_t n);
		for (int i = 0; i < n; i++)
			exp_q.push_back(ref_word(l2_cache_pkg::cpu_addr_t'(a + i)));
		issue_read(a, n);
	endtask

	task automatic write_ddr(input l2_cache_pkg::cpu_addr_t a, input l2_cache_pkg::cpu_data_t d,
			input l2_cache_pkg::cpu_be_t be);
		for (int i = 0; i < 4; i++)
			if (be[i])
				ddr_ref[a[17:1]][32 * a[0] + 8 * i +: 8] = d[8 * i +: 8];
		cpu_request(a, d, be, 4'd1, 1'b0, 1'b1);
		wait_idle();
	endtask

	always @(posedge CLK)
		cyc <= cyc + 1;

	initial begin
		wait (cyc == MAX_CYCLES);
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	// bus monitors and read data checks
	always @(negedge CLK) begin
		if (rst_n) begin
			if (DDRAM_RD && !DDRAM_BUSY) begin
				ddr_rd_cnt++;
				assert (DDRAM_BURSTCNT == 8'd8) // whole line per fill
				else report_error($sformatf("DDR read burst %0d, expected 8", DDRAM_BURSTCNT));
			end
			if (DDRAM_WE && !DDRAM_BUSY) begin
				ddr_we_cnt++;
				assert (DDRAM_BURSTCNT == 8'd1)
				else report_error($sformatf("DDR write burst %0d, expected 1", DDRAM_BURSTCNT));
			end
			if (VGA_WE) begin
				vga_we_cnt++;
				vga_offs.push_back(VGA_ADDR[1:0]);
			end
			assert (!(no_ddr_rd && DDRAM_RD)) else report_error("DDRAM_RD raised on a hit");
			assert (!(no_ddr_we && DDRAM_WE)) else report_error("DDRAM_WE raised for a ROM write");
			if (CPU_DOUT_READY) begin
				ready_cyc = cyc;
				assert (exp_q.size() != 0) else report_error("CPU_DOUT_READY with no read pending");
				if (exp_q.size() != 0) begin
					assert (CPU_DOUT == exp_q[0])
					else report_error($sformatf("CPU_DOUT %h, expected %h", CPU_DOUT, exp_q[0]));
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		l2_cache_pkg::cpu_addr_t a;
		l2_cache_pkg::cpu_addr_t wa;
		l2_cache_pkg::cpu_addr_t line [5];
		l2_cache_pkg::cpu_data_t d;
		l2_cache_pkg::cpu_be_t   be;
		logic [16:0]             b;
		logic [4:0]              s;
		int                      cnt0;
		int                      cnt1;

		void'($urandom(32'hd934));
		rst_n        = 1'b0;
		CPU_ADDR     = '0;
		CPU_DIN      = '0;
		CPU_BE       = '0;
		CPU_BURSTCNT = '0;
		CPU_RD       = 1'b0;
		CPU_WE       = 1'b0;
		VGA_MODE     = 3'b000;
		for (int i = 0; i < MEM_SIZE; i++) begin
			ddr_ref[i] = ddr_fill(17'(i));
			vga_ref[i] = vga_fill(17'(i));
		end
		repeat (2) @(posedge CLK);
		#2 rst_n = 1'b1;
		wait_idle(); // INIT sweep over all sets

		a  = l2_cache_pkg::cpu_addr_t'($urandom & 32'h0fffc);
		wa = a + l2_cache_pkg::cpu_addr_t'($urandom & 3);
		d  = $urandom;
		be = l2_cache_pkg::cpu_be_t'($urandom_range(14, 1)); // at least one byte kept
		write_ddr(wa, d, be);
		read_ddr(a, 4'd4);
		assert (ddr_model_i.mem[wa[17:1]] == ddr_ref[wa[17:1]])
		else report_error("DDR model contents differ from the reference");
		test_end(1, "write then burst read");

		no_ddr_rd = 1'b1; // line filled just before
		read_ddr(a, 4'd4);
		no_ddr_rd = 1'b0;
		assert (ready_cyc - acc_cyc == 5)
		else report_error($sformatf("last hit beat %0d cycles after accept", ready_cyc - acc_cyc));
		test_end(2, "repeated read hits");

		s = 5'($urandom);
		for (int k = 0; k < 5; k++) begin
			line[k] = l2_cache_pkg::cpu_addr_t'({8'ha0 + 8'(k), s, 4'($urandom)});
			read_ddr(line[k], 4'd1);
		end
		cnt0 = ddr_rd_cnt;
		read_ddr(line[0], 4'd1);
		assert (ddr_rd_cnt == cnt0 + 1) else report_error("evicted line was not fetched again");
		no_ddr_rd = 1'b1;
		read_ddr(line[4], 4'd1);
		no_ddr_rd = 1'b0;
		test_end(3, "lru eviction");

		a         = l2_cache_pkg::cpu_addr_t'(32'h30000 | ($urandom & 32'hffff));
		cnt0      = ddr_we_cnt;
		no_ddr_we = 1'b1;
		cpu_request(a, $urandom, 4'hf, 4'd1, 1'b0, 1'b1);
		wait_idle();
		read_ddr(a, 4'd1); // old data stays
		no_ddr_we = 1'b0;
		assert (ddr_we_cnt == cnt0) else report_error("ROM write reached DDR");
		test_end(4, "rom write dropped");

		VGA_MODE = 3'b100;
		@(posedge CLK);
		#2;
		a    = l2_cache_pkg::cpu_addr_t'(32'h28000 | ($urandom & 32'h7fff));
		b    = {a[14:0], 2'b00};
		d    = $urandom;
		cnt0 = vga_we_cnt;
		vga_offs.delete();
		cpu_request(a, d, 4'b0110, 4'd1, 1'b0, 1'b1);
		wait_idle();
		vga_ref[b + 1] = d[15:8];
		vga_ref[b + 2] = d[23:16];
		assert (vga_we_cnt == cnt0 + 2 && vga_offs.size() == 2 && vga_offs[0] == 2'd1
			&& vga_offs[1] == 2'd2)
		else report_error("VGA_WE strobes do not follow byte enables 0110");
		exp_q.push_back({vga_ref[b + 3], vga_ref[b + 2], vga_ref[b + 1], vga_ref[b]});
		issue_read(a, 4'd1);
		VGA_MODE = 3'b000; // window closed, same address is plain RAM
		@(posedge CLK);
		#2;
		cnt0 = ddr_we_cnt;
		cnt1 = vga_we_cnt;
		write_ddr(a, $urandom, 4'hf);
		read_ddr(a, 4'd1);
		assert (ddr_we_cnt == cnt0 + 1 && vga_we_cnt == cnt1)
		else report_error("write with VGA_MODE 000 did not go to DDR");
		test_end(5, "vga window");

		a = l2_cache_pkg::cpu_addr_t'(32'h0400_0000 | ($urandom & 32'h3fff_ffff));
		exp_q.push_back('0);
		no_ddr_rd = 1'b1;
		issue_read(a, 4'd1);
		no_ddr_rd = 1'b0;
		assert (ready_cyc - acc_cyc == 2)
		else report_error($sformatf("ready %0d cycles after accept", ready_cyc - acc_cyc));
		test_end(6, "read above ram");

		$display("6 tests run, %0d failed, %0d errors", failed_tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
hdl/l2_cache_pkg.sv
hdl/cpu_region_decode.sv
hdl/cache_way_store.sv
hdl/l2_cache_ctrl.sv
hdl/vga_byte_bridge.sv
hdl/cpu_read_return.sv
hdl/l2_cache_top.sv
sim/mem_models.sv
sim/tb_l2_cache.sv
